// ==== hw/l2_pkg.sv ====
// Cache geometry, status codes, address union and the request and response structs
package l2_pkg;

    localparam int ADDR_BITS   = 32;
    localparam int LINE_BYTES  = 16;
    localparam int LINE_BITS   = 128;
    localparam int OFFSET_BITS = 4;
    localparam int INDEX_BITS  = 6;
    localparam int TAG_BITS    = 22;
    localparam int NUM_LINES   = 64;
    localparam int NUM_PORTS   = 2;

    typedef enum logic [1:0] {
        STATUS_OKAY        = 2'd0,
        STATUS_LOAD_FAULT  = 2'd1,
        STATUS_STORE_FAULT = 2'd2
    } l2_status_e;

    // Tag, index and byte offset of one address, most significant first
    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] offset;
    } l2_addr_fields_t;

    typedef union packed {
        logic [ADDR_BITS-1:0] word;
        l2_addr_fields_t      fields;
    } l2_addr_u;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        l2_addr_u              addr;
        logic [LINE_BITS-1:0]  wdata;
        logic [LINE_BYTES-1:0] wstrb;
    } l1_req_t;

    typedef struct packed {
        logic                 valid;
        logic [LINE_BITS-1:0] rdata;
        l2_status_e           status;
    } l1_resp_t;

    // Same fields as l1_req_t, the cache never sees which port asked
    typedef struct packed {
        logic                  valid;
        logic                  write;
        l2_addr_u              addr;
        logic [LINE_BITS-1:0]  wdata;
        logic [LINE_BYTES-1:0] wstrb;
    } l2_req_t;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [ADDR_BITS-1:0]  addr;
        logic [LINE_BITS-1:0]  wdata;
        logic [LINE_BYTES-1:0] wstrb;
    } mem_req_t;

    typedef struct packed {
        logic                 valid;
        logic [LINE_BITS-1:0] rdata;
        logic                 fault;
    } mem_resp_t;

endpackage

// ==== hw/l2_destination.sv ====
// Round-robin arbiter for the L1 ports with owner tracking and response routing
module l2_destination (
    input  logic               i_clk,
    input  logic               i_reset,
    input  l2_pkg::l1_req_t    i_l1_req [l2_pkg::NUM_PORTS],
    output logic [l2_pkg::NUM_PORTS-1:0] o_l1_ready,
    output l2_pkg::l1_resp_t   o_l1_resp [l2_pkg::NUM_PORTS],
    output l2_pkg::l2_req_t    o_req,
    input  logic               i_req_ready,
    input  l2_pkg::l1_resp_t   i_resp
);

    localparam int PORT_BITS = $clog2(l2_pkg::NUM_PORTS);

    l2_pkg::l2_req_t      req_q;
    logic                 busy_q;
    logic [PORT_BITS-1:0] prio_q;
    logic [PORT_BITS-1:0] owner_q;
    logic [PORT_BITS-1:0] cand;
    logic [PORT_BITS-1:0] grant_idx;
    logic                 grant_valid;
    logic                 accept;

    // Scan the ports starting from the one that currently holds priority
    always_comb begin
        grant_valid = 1'b0;
        grant_idx   = prio_q;
        cand        = prio_q;
        for (int k = 0; k < l2_pkg::NUM_PORTS; k++) begin
            cand = PORT_BITS'((int'(prio_q) + k) % l2_pkg::NUM_PORTS);
            if (!grant_valid && i_l1_req[cand].valid) begin
                grant_valid = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    // Only the granted port sees ready while a request is pending,
    // so two ports never transfer in the same cycle
    always_comb begin
        for (int p = 0; p < l2_pkg::NUM_PORTS; p++) begin
            o_l1_ready[p] = !busy_q && i_req_ready
                            && (!grant_valid || grant_idx == PORT_BITS'(p));
        end
    end

    assign accept = grant_valid && !busy_q && i_req_ready;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            req_q.valid <= 1'b0;
            busy_q      <= 1'b0;
            prio_q      <= '0;
            owner_q     <= '0;
        end else begin
            if (accept) begin
                req_q.valid <= 1'b1;
                req_q.write <= i_l1_req[grant_idx].write;
                req_q.addr  <= i_l1_req[grant_idx].addr;
                req_q.wdata <= i_l1_req[grant_idx].wdata;
                req_q.wstrb <= i_l1_req[grant_idx].wstrb;
                busy_q      <= 1'b1;
                owner_q     <= grant_idx;
                prio_q      <= PORT_BITS'((int'(grant_idx) + 1) % l2_pkg::NUM_PORTS);
            end else if (req_q.valid && i_req_ready) begin
                // Cache took the request, keep busy until its response
                req_q.valid <= 1'b0;
            end
            if (i_resp.valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign o_req = req_q;

    // Payload goes to every port, the valid pulse only to the owner
    always_comb begin
        for (int p = 0; p < l2_pkg::NUM_PORTS; p++) begin
            o_l1_resp[p]       = i_resp;
            o_l1_resp[p].valid = i_resp.valid && (owner_q == PORT_BITS'(p));
        end
    end

endmodule

// ==== hw/l2_cache.sv ====
// Direct-mapped write-back cache with lookup, writeback, refill and flush FSM
module l2_cache (
    input  logic              i_clk,
    input  logic              i_reset,
    input  l2_pkg::l2_req_t   i_req,
    output logic              o_req_ready,
    output l2_pkg::l1_resp_t  o_resp,
    output l2_pkg::mem_req_t  o_mem_req,
    input  logic              i_mem_req_ready,
    input  l2_pkg::mem_resp_t i_mem_resp,
    input  logic              i_flush_valid,
    output logic              o_flush_end
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WB,
        S_RF,
        S_FL_READ,
        S_FL_CHECK,
        S_FL_WB
    } state_e;

    logic [l2_pkg::TAG_BITS-1:0]  tag_mem  [l2_pkg::NUM_LINES];
    logic [l2_pkg::LINE_BITS-1:0] data_mem [l2_pkg::NUM_LINES];
    logic [l2_pkg::NUM_LINES-1:0] valid_q;
    logic [l2_pkg::NUM_LINES-1:0] dirty_q;

    state_e                        state_q;
    l2_pkg::l2_req_t               req_q;
    l2_pkg::l1_resp_t              resp_q;
    l2_pkg::mem_req_t              mem_req_q;
    logic [l2_pkg::TAG_BITS-1:0]   rd_tag_q;
    logic [l2_pkg::LINE_BITS-1:0]  rd_data_q;
    logic [l2_pkg::INDEX_BITS-1:0] flush_idx_q;
    logic                          flush_pend_q;
    logic                          flush_end_q;

    logic                          flushing;
    logic                          flush_last;
    logic [l2_pkg::INDEX_BITS-1:0] line_idx;
    logic [l2_pkg::INDEX_BITS-1:0] rd_idx;
    logic                          hit;
    logic [l2_pkg::LINE_BITS-1:0]  write_line;
    logic [l2_pkg::LINE_BITS-1:0]  fill_line;
    logic                          arr_we;
    l2_pkg::l2_addr_u              wb_addr;
    l2_pkg::l2_addr_u              fill_addr;
    l2_pkg::mem_req_t              wb_req;
    l2_pkg::mem_req_t              fill_req;

    function automatic logic [l2_pkg::LINE_BITS-1:0] merge_line(
        input logic [l2_pkg::LINE_BITS-1:0]  old_line,
        input logic [l2_pkg::LINE_BITS-1:0]  new_line,
        input logic [l2_pkg::LINE_BYTES-1:0] strb
    );
        logic [l2_pkg::LINE_BITS-1:0] m;
        m = old_line;
        for (int b = 0; b < l2_pkg::LINE_BYTES; b++) begin
            if (strb[b]) begin
                m[8*b +: 8] = new_line[8*b +: 8];
            end
        end
        return m;
    endfunction

    assign flushing   = (state_q == S_FL_READ) || (state_q == S_FL_CHECK)
                        || (state_q == S_FL_WB);
    assign flush_last = (flush_idx_q == l2_pkg::INDEX_BITS'(l2_pkg::NUM_LINES - 1));
    assign line_idx   = flushing ? flush_idx_q : req_q.addr.fields.index;
    assign rd_idx     = (state_q == S_IDLE) ? i_req.addr.fields.index : flush_idx_q;
    assign hit        = valid_q[line_idx] && (rd_tag_q == req_q.addr.fields.tag);
    assign write_line = merge_line(rd_data_q, req_q.wdata, req_q.wstrb);
    assign fill_line  = req_q.write ? merge_line(i_mem_resp.rdata, req_q.wdata, req_q.wstrb)
                                    : i_mem_resp.rdata;
    assign arr_we     = (state_q == S_LOOKUP && hit && req_q.write)
                        || (state_q == S_RF && i_mem_resp.valid && !i_mem_resp.fault);

    // Line requests toward memory, a victim writeback and a refill read
    always_comb begin
        wb_addr              = '0;
        wb_addr.fields.tag   = rd_tag_q;
        wb_addr.fields.index = line_idx;
        wb_req.valid         = 1'b1;
        wb_req.write         = 1'b1;
        wb_req.addr          = wb_addr.word;
        wb_req.wdata         = rd_data_q;
        wb_req.wstrb         = '1;

        fill_addr               = req_q.addr;
        fill_addr.fields.offset = '0;
        fill_req.valid          = 1'b1;
        fill_req.write          = 1'b0;
        fill_req.addr           = fill_addr.word;
        fill_req.wdata          = '0;
        fill_req.wstrb          = '0;
    end

    // Tag and data arrays with a registered read port
    always_ff @(posedge i_clk) begin
        if (arr_we) begin
            tag_mem[line_idx]  <= req_q.addr.fields.tag;
            data_mem[line_idx] <= (state_q == S_LOOKUP) ? write_line : fill_line;
        end
        if (state_q == S_IDLE || state_q == S_FL_READ) begin
            rd_tag_q  <= tag_mem[rd_idx];
            rd_data_q <= data_mem[rd_idx];
        end
    end

    assign o_req_ready = (state_q == S_IDLE) && !flush_pend_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q         <= S_IDLE;
            valid_q         <= '0;
            dirty_q         <= '0;
            flush_idx_q     <= '0;
            flush_pend_q    <= 1'b0;
            flush_end_q     <= 1'b0;
            resp_q.valid    <= 1'b0;
            mem_req_q.valid <= 1'b0;
        end else begin
            resp_q.valid <= 1'b0;
            flush_end_q  <= 1'b0;
            if (mem_req_q.valid && i_mem_req_ready) begin
                mem_req_q.valid <= 1'b0;
            end
            case (state_q)
                S_IDLE: begin
                    if (flush_pend_q) begin
                        flush_pend_q <= 1'b0;
                        flush_idx_q  <= '0;
                        state_q      <= S_FL_READ;
                    end else if (i_req.valid) begin
                        req_q   <= i_req;
                        state_q <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        resp_q.valid  <= 1'b1;
                        resp_q.rdata  <= req_q.write ? write_line : rd_data_q;
                        resp_q.status <= l2_pkg::STATUS_OKAY;
                        if (req_q.write) begin
                            dirty_q[line_idx] <= 1'b1;
                        end
                        state_q <= S_IDLE;
                    end else if (valid_q[line_idx] && dirty_q[line_idx]) begin
                        mem_req_q <= wb_req;
                        state_q   <= S_WB;
                    end else begin
                        mem_req_q <= fill_req;
                        state_q   <= S_RF;
                    end
                end
                S_WB: begin
                    if (i_mem_resp.valid) begin
                        if (i_mem_resp.fault) begin
                            // Victim keeps its dirty data, the request is dropped
                            resp_q.valid  <= 1'b1;
                            resp_q.rdata  <= '0;
                            resp_q.status <= l2_pkg::STATUS_STORE_FAULT;
                            state_q       <= S_IDLE;
                        end else begin
                            dirty_q[line_idx] <= 1'b0;
                            mem_req_q         <= fill_req;
                            state_q           <= S_RF;
                        end
                    end
                end
                S_RF: begin
                    if (i_mem_resp.valid) begin
                        resp_q.valid <= 1'b1;
                        if (i_mem_resp.fault) begin
                            valid_q[line_idx] <= 1'b0;
                            dirty_q[line_idx] <= 1'b0;
                            resp_q.rdata      <= '0;
                            resp_q.status     <= l2_pkg::STATUS_LOAD_FAULT;
                        end else begin
                            valid_q[line_idx] <= 1'b1;
                            dirty_q[line_idx] <= req_q.write;
                            resp_q.rdata      <= fill_line;
                            resp_q.status     <= l2_pkg::STATUS_OKAY;
                        end
                        state_q <= S_IDLE;
                    end
                end
                S_FL_READ: begin
                    state_q <= S_FL_CHECK;
                end
                S_FL_CHECK, S_FL_WB: begin
                    if (state_q == S_FL_CHECK && valid_q[line_idx] && dirty_q[line_idx]) begin
                        mem_req_q <= wb_req;
                        state_q   <= S_FL_WB;
                    end else if (state_q == S_FL_CHECK || i_mem_resp.valid) begin
                        valid_q[line_idx] <= 1'b0;
                        dirty_q[line_idx] <= 1'b0;
                        if (flush_last) begin
                            flush_end_q <= 1'b1;
                            state_q     <= S_IDLE;
                        end else begin
                            flush_idx_q <= flush_idx_q + 1'b1;
                            state_q     <= S_FL_READ;
                        end
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
            // A pulse during a request is kept until the cache is idle again
            if (i_flush_valid) begin
                flush_pend_q <= 1'b1;
            end
        end
    end

    assign o_resp      = resp_q;
    assign o_mem_req   = mem_req_q;
    assign o_flush_end = flush_end_q;

endmodule

// ==== hw/l2_mem_bridge.sv ====
// Bridge from cache line requests to the held external memory bus request
module l2_mem_bridge (
    input  logic              i_clk,
    input  logic              i_reset,
    input  l2_pkg::mem_req_t  i_req,
    output logic              o_req_ready,
    output l2_pkg::mem_resp_t o_resp,
    output l2_pkg::mem_req_t  o_mem,
    input  l2_pkg::mem_resp_t i_mem
);

    typedef enum logic {
        B_IDLE,
        B_BUSY
    } bridge_state_e;

    bridge_state_e     state_q;
    l2_pkg::mem_req_t  mem_q;
    l2_pkg::mem_resp_t resp_q;

    // One request at a time, a stalled bus keeps the cache waiting
    assign o_req_ready = (state_q == B_IDLE);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q      <= B_IDLE;
            mem_q.valid  <= 1'b0;
            resp_q.valid <= 1'b0;
        end else begin
            resp_q.valid <= 1'b0;
            case (state_q)
                B_IDLE: begin
                    if (i_req.valid) begin
                        // Bus fields stay in this register until the response
                        mem_q.valid <= 1'b1;
                        mem_q.write <= i_req.write;
                        mem_q.addr  <= i_req.addr;
                        mem_q.wdata <= i_req.wdata;
                        mem_q.wstrb <= i_req.wstrb;
                        state_q     <= B_BUSY;
                    end
                end
                B_BUSY: begin
                    if (i_mem.valid) begin
                        resp_q.valid <= 1'b1;
                        resp_q.rdata <= i_mem.rdata;
                        resp_q.fault <= i_mem.fault;
                        mem_q.valid  <= 1'b0;
                        state_q      <= B_IDLE;
                    end
                end
                default: begin
                    state_q <= B_IDLE;
                end
            endcase
        end
    end

    assign o_mem  = mem_q;
    assign o_resp = resp_q;

endmodule

// ==== hw/l2_top.sv ====
// Top level of the L2 subsystem with destination, cache and memory bridge
module l2_top (
    input  logic              i_clk,
    input  logic              i_reset,
    input  l2_pkg::l1_req_t   i_l1_req [l2_pkg::NUM_PORTS],
    output logic [l2_pkg::NUM_PORTS-1:0] o_l1_ready,
    output l2_pkg::l1_resp_t  o_l1_resp [l2_pkg::NUM_PORTS],
    input  logic              i_flush_valid,
    output logic              o_flush_end,
    output l2_pkg::mem_req_t  o_mem,
    input  l2_pkg::mem_resp_t i_mem
);

    // Destination to cache
    l2_pkg::l2_req_t   req;
    logic              req_ready;
    l2_pkg::l1_resp_t  cache_resp;

    // Cache to bridge
    l2_pkg::mem_req_t  mem_req;
    logic              mem_req_ready;
    l2_pkg::mem_resp_t mem_resp;

    l2_destination dst0 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_l1_req    (i_l1_req),
        .o_l1_ready  (o_l1_ready),
        .o_l1_resp   (o_l1_resp),
        .o_req       (req),
        .i_req_ready (req_ready),
        .i_resp      (cache_resp)
    );

    l2_cache cache0 (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_req           (req),
        .o_req_ready     (req_ready),
        .o_resp          (cache_resp),
        .o_mem_req       (mem_req),
        .i_mem_req_ready (mem_req_ready),
        .i_mem_resp      (mem_resp),
        .i_flush_valid   (i_flush_valid),
        .o_flush_end     (o_flush_end)
    );

    l2_mem_bridge bridge0 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req       (mem_req),
        .o_req_ready (mem_req_ready),
        .o_resp      (mem_resp),
        .o_mem       (o_mem),
        .i_mem       (i_mem)
    );

endmodule

// ==== test/l2_props.sv ====
// Bound assertions on the L2 top level for bus stability, flush blocking and reset values
module l2_props (
    input logic                           i_clk,
    input logic                           i_reset,
    input logic [l2_pkg::NUM_PORTS-1:0]   o_l1_ready,
    input l2_pkg::l1_resp_t               o_l1_resp [l2_pkg::NUM_PORTS],
    input logic                           i_flush_valid,
    input logic                           o_flush_end,
    input l2_pkg::mem_req_t               o_mem,
    input l2_pkg::mem_resp_t              i_mem
);

    logic flush_busy_q;

    // Set from the edge that sees the flush pulse until the end pulse
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            flush_busy_q <= 1'b0;
        end else if (i_flush_valid) begin
            flush_busy_q <= 1'b1;
        end else if (o_flush_end) begin
            flush_busy_q <= 1'b0;
        end
    end

    mem_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        o_mem.valid && !i_mem.valid |=> $stable(o_mem))
        else $error("o_mem changed while waiting for the bus response");

    flush_blocks: assert property (@(posedge i_clk) disable iff (i_reset)
        flush_busy_q && !o_flush_end |-> o_l1_ready == '0)
        else $error("o_l1_ready went high during a flush");

    reset_quiet: assert property (@(posedge i_clk)
        i_reset |=> !o_l1_resp[0].valid && !o_l1_resp[1].valid && !o_mem.valid && !o_flush_end)
        else $error("outputs not cleared in the cycle after reset");

    // A response ends the single outstanding request, so no port may be ready during it
    one_resp: assert property (@(posedge i_clk) disable iff (i_reset)
        o_l1_resp[0].valid || o_l1_resp[1].valid
            |-> !(o_l1_resp[0].valid && o_l1_resp[1].valid) && o_l1_ready == '0)
        else $error("response entries overlap or a port was ready during a response");

endmodule

bind l2_top l2_props props0 (.*);

// ==== test/l2_checker.sv ====
// Checker with shadow memory, reference model and per-port response comparison
module l2_checker #(
    parameter logic [31:0] FAULT_BASE = 32'h0001_0000,
    parameter int          MEM_BYTES  = 4096
) (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  l2_pkg::l1_req_t              i_l1_req [l2_pkg::NUM_PORTS],
    input  logic [l2_pkg::NUM_PORTS-1:0] i_l1_ready,
    input  l2_pkg::l1_resp_t             i_l1_resp [l2_pkg::NUM_PORTS],
    output int                           o_errors,
    output int                           o_checks,
    output int                           o_pending
);

    logic [7:0]       shadow [MEM_BYTES];
    l2_pkg::l1_resp_t exp0 [$];
    l2_pkg::l1_resp_t exp1 [$];
    int               errors = 0;
    int               checks = 0;
    int               pending = 0;

    // Bytes never written hold a pattern folded from the whole address
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
    endfunction

    initial begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            shadow[i] = fill_byte(32'(i));
        end
    end

    // Expected response of one access, a write also updates the shadow
    function automatic l2_pkg::l1_resp_t model_access(input logic w, input logic [31:0] a,
            input logic [l2_pkg::LINE_BITS-1:0] d, input logic [l2_pkg::LINE_BYTES-1:0] s);
        l2_pkg::l1_resp_t r;
        int               base;
        r.valid = 1'b1;
        r.rdata = '0;
        // Fault region lines are never allocated, so every access there faults on refill
        if (a[31:12] == FAULT_BASE[31:12]) begin
            r.status = l2_pkg::STATUS_LOAD_FAULT;
            return r;
        end
        base = int'({a[11:4], 4'h0});
        for (int b = 0; b < l2_pkg::LINE_BYTES; b++) begin
            if (w && s[b]) begin
                shadow[base + b] = d[8*b +: 8];
            end
            r.rdata[8*b +: 8] = shadow[base + b];
        end
        r.status = l2_pkg::STATUS_OKAY;
        return r;
    endfunction

    task automatic compare(input int p, input l2_pkg::l1_resp_t e, input l2_pkg::l1_resp_t g);
        checks++;
        if (g.rdata !== e.rdata) begin
            errors++;
            $display("error o_l1_resp[%0d].rdata: got %032h expected %032h", p, g.rdata, e.rdata);
        end
        if (g.status !== e.status) begin
            errors++;
            $display("error o_l1_resp[%0d].status: got %0h expected %0h", p, g.status, e.status);
        end
    endtask

    always @(posedge i_clk) begin : watch
        l2_pkg::l1_resp_t e;
        if (!i_reset) begin
            // Responses first, a port never has a response and an acceptance together
            for (int p = 0; p < l2_pkg::NUM_PORTS; p++) begin
                if (i_l1_resp[p].valid) begin
                    if ((p == 0 ? exp0.size() : exp1.size()) == 0) begin
                        errors++;
                        $display("response on port %0d with no request waiting for it", p);
                    end else begin
                        e = (p == 0) ? exp0.pop_front() : exp1.pop_front();
                        compare(p, e, i_l1_resp[p]);
                    end
                end
            end
            for (int p = 0; p < l2_pkg::NUM_PORTS; p++) begin
                if (i_l1_req[p].valid && i_l1_ready[p]) begin
                    e = model_access(i_l1_req[p].write, i_l1_req[p].addr.word,
                                     i_l1_req[p].wdata, i_l1_req[p].wstrb);
                    if (p == 0) exp0.push_back(e);
                    else exp1.push_back(e);
                end
            end
        end
        pending = exp0.size() + exp1.size();
    end

    assign o_errors  = errors;
    assign o_checks  = checks;
    assign o_pending = pending;

endmodule

// ==== test/l2_tb.sv ====
// Testbench top with clock, reset, memory model, directed and random tests and watchdog
module l2_tb;

    localparam logic [31:0] FAULT_BASE     = 32'h0001_0000;
    localparam int          MEM_BYTES      = 4096;
    localparam int          MEM_MAX_DELAY  = 4;
    localparam int          RAND_REQS      = 300;
    localparam int          DIRECTED_REQS  = 20;
    localparam int          MISS_CYCLES    = 2 * (MEM_MAX_DELAY + 3) + 6;
    localparam int          FLUSH_CYCLES   = l2_pkg::NUM_LINES * (MEM_MAX_DELAY + 6);
    localparam int          TIMEOUT_CYCLES = (RAND_REQS + DIRECTED_REQS) * MISS_CYCLES
                                             + FLUSH_CYCLES;

    logic                         clk;
    logic                         reset;
    l2_pkg::l1_req_t              l1_req [l2_pkg::NUM_PORTS];
    logic [l2_pkg::NUM_PORTS-1:0] l1_ready;
    l2_pkg::l1_resp_t             l1_resp [l2_pkg::NUM_PORTS];
    logic                         flush_valid;
    logic                         flush_end;
    l2_pkg::mem_req_t             mem_req;
    l2_pkg::mem_resp_t            mem_resp;

    integer     seed = 32'ha7ca;
    logic [7:0] mem [MEM_BYTES];
    logic [1:0] acc_q;
    logic [1:0] got_q;
    logic       flush_end_q;
    int         tb_errors;
    int         err_mark;
    int         resp_cycles;
    int         chk_errors;
    int         chk_checks;
    int         chk_pending;

    l2_top UUT (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_l1_req      (l1_req),
        .o_l1_ready    (l1_ready),
        .o_l1_resp     (l1_resp),
        .i_flush_valid (flush_valid),
        .o_flush_end   (flush_end),
        .o_mem         (mem_req),
        .i_mem         (mem_resp)
    );

    l2_checker #(.FAULT_BASE(FAULT_BASE), .MEM_BYTES(MEM_BYTES)) chk (
        .i_clk     (clk),
        .i_reset   (reset),
        .i_l1_req  (l1_req),
        .i_l1_ready(l1_ready),
        .i_l1_resp (l1_resp),
        .o_errors  (chk_errors),
        .o_checks  (chk_checks),
        .o_pending (chk_pending)
    );

    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Handshakes seen at a rising edge, read back on the next falling edge
    always @(posedge clk) begin
        for (int p = 0; p < l2_pkg::NUM_PORTS; p++) begin
            acc_q[p] <= l1_req[p].valid && l1_ready[p];
            got_q[p] <= l1_resp[p].valid;
        end
        flush_end_q <= flush_end;
    end

    // External memory, answers after a random delay and faults reads in the fault region
    initial begin : mem_model
        int          delay;
        logic [31:0] a;
        mem_resp = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = fill_byte(32'(i));
        end
        forever begin
            @(negedge clk);
            mem_resp.valid = 1'b0;
            if (!reset && mem_req.valid) begin
                delay = 1 + int'($unsigned($random(seed)) % MEM_MAX_DELAY);
                repeat (delay) @(negedge clk);
                a = mem_req.addr;
                mem_resp.rdata = '0;
                mem_resp.fault = 1'b0;
                if (a[31:12] == FAULT_BASE[31:12]) begin
                    mem_resp.fault = !mem_req.write;
                end else begin
                    for (int b = 0; b < l2_pkg::LINE_BYTES; b++) begin
                        if (mem_req.write && mem_req.wstrb[b] && a < MEM_BYTES) begin
                            mem[int'(a[11:0]) + b] = mem_req.wdata[8*b +: 8];
                        end
                        if (!mem_req.write) begin
                            mem_resp.rdata[8*b +: 8] = (a < MEM_BYTES) ? mem[int'(a[11:0]) + b]
                                                                      : fill_byte(a + 32'(b));
                        end
                    end
                end
                mem_resp.valid = 1'b1;
            end
        end
    end

    // Drive one request on a port, returns on the falling edge after it was accepted
    task automatic issue(input int p, input logic w, input logic [31:0] a,
            input logic [l2_pkg::LINE_BITS-1:0] d, input logic [l2_pkg::LINE_BYTES-1:0] s);
        l1_req[p].valid     = 1'b1;
        l1_req[p].write     = w;
        l1_req[p].addr.word = a;
        l1_req[p].wdata     = d;
        l1_req[p].wstrb     = s;
        do @(negedge clk); while (!acc_q[p]);
        l1_req[p].valid = 1'b0;
    endtask

    // One request on a port, returns on the falling edge after its response
    task automatic access(input int p, input logic w, input logic [31:0] a,
            input logic [l2_pkg::LINE_BITS-1:0] d, input logic [l2_pkg::LINE_BYTES-1:0] s);
        issue(p, w, a, d, s);
        resp_cycles = 0;
        do begin
            @(negedge clk);
            resp_cycles++;
        end while (!got_q[p]);
    endtask

    // A hit is answered in the third cycle after the acceptance cycle
    task automatic check_hit_latency(input string kind);
        if (resp_cycles != 3) begin
            tb_errors++;
            $display("%s hit answered %0d cycles after acceptance instead of 3",
                     kind, resp_cycles);
        end
    endtask

    // Small window of two indexes and four tags so lines keep evicting each other.
    // Each port drives its next request without waiting for the previous response
    task automatic random_traffic(input int p, input int n);
        logic [31:0]                  r;
        logic [l2_pkg::LINE_BITS-1:0] d;
        logic [31:0]                  s;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            d = {$random(seed), $random(seed), $random(seed), $random(seed)};
            s = $random(seed);
            issue(p, r[8], {20'h0, r[1:0], 5'h0, r[2], r[7:4]}, d, s[15:0]);
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = chk_errors + tb_errors - err_mark;
        if (n == 0) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, n);
        err_mark = chk_errors + tb_errors;
    endtask

    initial begin
        reset       = 1'b1;
        flush_valid = 1'b0;
        tb_errors   = 0;
        err_mark    = 0;
        resp_cycles = 0;
        for (int p = 0; p < l2_pkg::NUM_PORTS; p++) begin
            l1_req[p] = '0;
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (l1_ready !== 2'b11) begin
            tb_errors++;
            $display("error o_l1_ready: got %h expected %h", l1_ready, 2'b11);
        end

        access(0, 1'b0, 32'h200, '0, '0);
        access(0, 1'b0, 32'h208, '0, '0);
        check_hit_latency("read");
        end_test("read miss then hit");

        access(0, 1'b1, 32'h100, {4{32'h11223344}}, 16'h00ff);
        access(1, 1'b1, 32'h100, {4{32'h99aabbcc}}, 16'hf000);
        check_hit_latency("write");
        access(1, 1'b0, 32'h100, '0, '0);
        access(0, 1'b0, 32'h104, '0, '0);
        end_test("partial writes merged");

        access(0, 1'b1, 32'h040, {4{32'hdeadbeef}}, 16'hffff);
        access(0, 1'b1, 32'h440, {4{32'hcafef00d}}, 16'h0f0f);
        access(1, 1'b0, 32'h040, '0, '0);
        access(1, 1'b0, 32'h440, '0, '0);
        end_test("dirty eviction");

        access(0, 1'b0, FAULT_BASE + 32'h20, '0, '0);
        access(1, 1'b0, FAULT_BASE + 32'h20, '0, '0);
        end_test("load fault");

        access(1, 1'b1, 32'h300, {4{32'h0badcafe}}, 16'hf00f);
        flush_valid = 1'b1;
        @(negedge clk);
        flush_valid = 1'b0;
        while (!flush_end_q) @(negedge clk);
        for (int i = 0; i < MEM_BYTES; i++) begin
            if (mem[i] !== chk.shadow[i]) begin
                tb_errors++;
                $display("error mem[%03h]: got %02h expected %02h", i, mem[i], chk.shadow[i]);
            end
        end
        access(0, 1'b0, 32'h300, '0, '0);
        access(0, 1'b0, 32'h440, '0, '0);
        end_test("flush");

        fork
            random_traffic(0, RAND_REQS / 2);
            random_traffic(1, RAND_REQS / 2);
        join
        repeat (MISS_CYCLES) @(negedge clk);
        if (chk_pending != 0) begin
            tb_errors++;
            $display("%0d requests never received a response", chk_pending);
        end
        end_test("random traffic");

        $display("checks %0d, errors %0d", chk_checks, chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the number of requests and the worst miss latency
    initial begin
        repeat (TIMEOUT_CYCLES + 10) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES + 10);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== files.f ====
hw/l2_pkg.sv
hw/l2_destination.sv
hw/l2_cache.sv
hw/l2_mem_bridge.sv
hw/l2_top.sv
test/l2_props.sv
test/l2_checker.sv
test/l2_tb.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert --top-module l2_tb -Mdir obj_dir -f files.f
	./obj_dir/Vl2_tb | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
